/* noc_alloc_macros.svh */
`ifndef NOC_ALLOC_MACROS_SVH
`define NOC_ALLOC_MACROS_SVH

// router dimensions shared by the allocator and its testbench

// virtual channels per port
`define NOC_V 4

// router ports, local port included
`define NOC_P 5

// destinations seen from one input port
// a port never routes back to itself
`define NOC_P_1 (`NOC_P - 1)

`endif

/* noc_alloc_pkg.sv */
`include "noc_alloc_macros.svh"

package noc_alloc_pkg;

    typedef logic [`NOC_V-1:0]   vc_vec_t;   // one bit per VC of a port
    typedef logic [`NOC_P_1-1:0] port_sel_t; // one-hot destination, own port skipped
    typedef logic [`NOC_P-1:0]   port_vec_t; // one bit per router port

    // everything an input port presents to the allocator
    typedef struct packed {
        vc_vec_t                   ivc_request;           // VC holds a flit
        vc_vec_t                   ovc_is_assigned;
        vc_vec_t                   assigned_ovc_not_full;
        vc_vec_t   [`NOC_V-1:0]    candidate_ovc;         // free output VCs per input VC
        port_sel_t [`NOC_V-1:0]    dest_port;             // routed destination per input VC
    } in_port_req_t;

    // allocation result returned to an input port
    typedef struct packed {
        vc_vec_t   sw_grant;          // VC that won the crossbar
        vc_vec_t   ovc_grant;         // VC that got a new output VC
        vc_vec_t   granted_ovc;       // which output VC it got
        port_sel_t granted_dest_port;
        logic      any_grant;
    } in_port_grant_t;

endpackage

/* rr_arbiter.sv */
module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic [WIDTH-1:0]   prio;    // one-hot, position with highest priority
    logic [2*WIDTH-1:0] req_dbl;
    logic [2*WIDTH-1:0] gnt_dbl;

    // doubled request vector handles the wrap around
    assign req_dbl = {request, request};

    // the borrow stops at the first request at or above prio
    // and that bit is the only one left set after the mask
    assign gnt_dbl = req_dbl & ~(req_dbl - {{WIDTH{1'b0}}, prio});

    assign grant     = gnt_dbl[WIDTH-1:0] | gnt_dbl[2*WIDTH-1:WIDTH];
    assign any_grant = |request;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio <= {{(WIDTH-1){1'b0}}, 1'b1}; // index 0 first
        end else if (any_grant) begin
            // one past the winner, so the winner drops to lowest
            prio <= {grant[WIDTH-2:0], grant[WIDTH-1]};
        end
    end

endmodule

/* sw_alloc_stage.sv */
`include "noc_alloc_macros.svh"

module sw_alloc_stage
    import noc_alloc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  vc_vec_t                request           [`NOC_P],
    input  port_sel_t [`NOC_V-1:0] dest_port         [`NOC_P],
    output vc_vec_t                ivc_grant         [`NOC_P],
    output port_sel_t              granted_dest_port [`NOC_P],
    output port_vec_t              out_port_busy
);

    vc_vec_t   in_gnt  [`NOC_P]; // first level winner per input port
    port_sel_t in_dest [`NOC_P]; // destination of that winner
    port_sel_t out_req [`NOC_P]; // per output, indexed by input port with self skipped
    port_sel_t out_gnt [`NOC_P];

    // first level, one VC per input port
    for (genvar i = 0; i < `NOC_P; i++) begin : g_in_arb
        rr_arbiter #(
            .WIDTH(`NOC_V)
        ) in_arb_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (request[i]),
            .grant     (in_gnt[i]),
            .any_grant ()
        );
    end

    // destination of the winning VC
    always_comb begin
        for (int i = 0; i < `NOC_P; i++) begin
            in_dest[i] = '0;
            for (int v = 0; v < `NOC_V; v++) begin
                if (in_gnt[i][v]) begin
                    in_dest[i] = in_dest[i] | dest_port[i][v];
                end
            end
        end
    end

    // gather requests per output port
    always_comb begin
        for (int o = 0; o < `NOC_P; o++) begin
            out_req[o] = '0;
            for (int j = 0; j < `NOC_P; j++) begin
                if (j < o) begin
                    out_req[o][j] = in_dest[j][o-1];   // seen from j, o sits one lower
                end else if (j > o) begin
                    out_req[o][j-1] = in_dest[j][o];
                end
            end
        end
    end

    // second level, one input port per output port
    for (genvar o = 0; o < `NOC_P; o++) begin : g_out_arb
        rr_arbiter #(
            .WIDTH(`NOC_P_1)
        ) out_arb_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (out_req[o]),
            .grant     (out_gnt[o]),
            .any_grant (out_port_busy[o])
        );
    end

    // route output grants back to the input ports
    always_comb begin
        for (int j = 0; j < `NOC_P; j++) begin
            granted_dest_port[j] = '0;
            for (int o = 0; o < `NOC_P; o++) begin
                if (o < j) begin
                    granted_dest_port[j][o] = out_gnt[o][j-1];
                end else if (o > j) begin
                    granted_dest_port[j][o-1] = out_gnt[o][j];
                end
            end
            // the VC keeps its grant only if its port won the output
            ivc_grant[j] = (|granted_dest_port[j]) ? in_gnt[j] : '0;
        end
    end

endmodule

/* spec_sw_alloc.sv */
`include "noc_alloc_macros.svh"

module spec_sw_alloc
    import noc_alloc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  vc_vec_t                nonspec_request   [`NOC_P],
    input  vc_vec_t                spec_request      [`NOC_P],
    input  port_sel_t [`NOC_V-1:0] dest_port         [`NOC_P],
    output vc_vec_t                sw_grant          [`NOC_P],
    output port_sel_t              granted_dest_port [`NOC_P],
    output port_vec_t              any_grant,
    output vc_vec_t                spec_winner       [`NOC_P],
    output port_sel_t              spec_dest         [`NOC_P]
);

    vc_vec_t   ns_ivc_grant [`NOC_P];
    port_sel_t ns_dest      [`NOC_P];
    port_vec_t ns_out_busy;
    vc_vec_t   sp_ivc_grant [`NOC_P];
    port_sel_t sp_dest      [`NOC_P];
    port_sel_t ns_busy_sel  [`NOC_P]; // busy outputs as seen from each input port

    sw_alloc_stage nonspec_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .request           (nonspec_request),
        .dest_port         (dest_port),
        .ivc_grant         (ns_ivc_grant),
        .granted_dest_port (ns_dest),
        .out_port_busy     (ns_out_busy)
    );

    sw_alloc_stage spec_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .request           (spec_request),
        .dest_port         (dest_port),
        .ivc_grant         (sp_ivc_grant),
        .granted_dest_port (sp_dest),
        .out_port_busy     ()
    );

    // non-speculative output grants, own port removed
    always_comb begin
        for (int j = 0; j < `NOC_P; j++) begin
            ns_busy_sel[j] = '0;
            for (int o = 0; o < `NOC_P; o++) begin
                if (o < j) begin
                    ns_busy_sel[j][o] = ns_out_busy[o];
                end else if (o > j) begin
                    ns_busy_sel[j][o-1] = ns_out_busy[o];
                end
            end
        end
    end

    // speculation survives only on a port and an output left idle
    always_comb begin
        for (int j = 0; j < `NOC_P; j++) begin
            if (|ns_dest[j]) begin
                spec_dest[j] = '0;   // input port already moves a flit
            end else begin
                spec_dest[j] = sp_dest[j] & ~ns_busy_sel[j];
            end
            spec_winner[j] = (|spec_dest[j]) ? sp_ivc_grant[j] : '0;

            sw_grant[j]          = ns_ivc_grant[j] | spec_winner[j];
            granted_dest_port[j] = ns_dest[j] | spec_dest[j];
            any_grant[j]         = |granted_dest_port[j];
        end
    end

endmodule

/* vc_alloc.sv */
`include "noc_alloc_macros.svh"

module vc_alloc
    import noc_alloc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  vc_vec_t              spec_winner   [`NOC_P],
    input  port_sel_t            spec_dest     [`NOC_P],
    input  vc_vec_t [`NOC_V-1:0] candidate_ovc [`NOC_P],
    output vc_vec_t              ovc_grant     [`NOC_P],
    output vc_vec_t              granted_ovc   [`NOC_P],
    output vc_vec_t              ovc_allocated [`NOC_P]
);

    vc_vec_t cand_req [`NOC_P]; // candidates of the accepted winner
    vc_vec_t cand_gnt [`NOC_P];
    logic    cand_any [`NOC_P];

    // candidate output VCs of the winning input VC
    always_comb begin
        for (int i = 0; i < `NOC_P; i++) begin
            cand_req[i] = '0;
            for (int v = 0; v < `NOC_V; v++) begin
                if (spec_winner[i][v]) begin
                    cand_req[i] = cand_req[i] | candidate_ovc[i][v];
                end
            end
        end
    end

    for (genvar i = 0; i < `NOC_P; i++) begin : g_ovc_arb
        rr_arbiter #(
            .WIDTH(`NOC_V)
        ) ovc_arb_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (cand_req[i]),
            .grant     (cand_gnt[i]),
            .any_grant (cand_any[i])
        );
    end

    always_comb begin
        for (int i = 0; i < `NOC_P; i++) begin
            ovc_grant[i]   = cand_any[i] ? spec_winner[i] : '0;
            granted_ovc[i] = cand_gnt[i];
        end
    end

    // scatter the picked VC onto the output port it belongs to
    always_comb begin
        for (int o = 0; o < `NOC_P; o++) begin
            ovc_allocated[o] = '0;
            for (int j = 0; j < `NOC_P; j++) begin
                if (o < j) begin
                    if (spec_dest[j][o]) begin
                        ovc_allocated[o] = ovc_allocated[o] | cand_gnt[j];
                    end
                end else if (o > j) begin
                    if (spec_dest[j][o-1]) begin
                        ovc_allocated[o] = ovc_allocated[o] | cand_gnt[j];
                    end
                end
            end
        end
    end

endmodule

/* comb_spec_alloc.sv */
`include "noc_alloc_macros.svh"

module comb_spec_alloc
    import noc_alloc_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  in_port_req_t   port_req      [`NOC_P],
    output in_port_grant_t port_grant    [`NOC_P],
    output vc_vec_t        ovc_allocated [`NOC_P]
);

    vc_vec_t                   nonspec_req [`NOC_P];
    vc_vec_t                   spec_req    [`NOC_P];
    port_sel_t [`NOC_V-1:0]    dest_port   [`NOC_P];
    vc_vec_t   [`NOC_V-1:0]    cand_ovc    [`NOC_P];
    vc_vec_t                   sw_grant    [`NOC_P];
    port_sel_t                 gnt_dest    [`NOC_P];
    port_vec_t                 any_grant;
    vc_vec_t                   spec_winner [`NOC_P];
    port_sel_t                 spec_dest   [`NOC_P];
    vc_vec_t                   ovc_grant   [`NOC_P];
    vc_vec_t                   granted_ovc [`NOC_P];

    always_comb begin
        for (int i = 0; i < `NOC_P; i++) begin
            dest_port[i] = port_req[i].dest_port;
            cand_ovc[i]  = port_req[i].candidate_ovc;
            // output VC held and room in it
            nonspec_req[i] = port_req[i].ivc_request & port_req[i].ovc_is_assigned
                             & port_req[i].assigned_ovc_not_full;
            for (int v = 0; v < `NOC_V; v++) begin
                // no output VC yet, needs at least one free candidate
                spec_req[i][v] = port_req[i].ivc_request[v] & ~port_req[i].ovc_is_assigned[v]
                                 & (|port_req[i].candidate_ovc[v]);
            end
        end
    end

    spec_sw_alloc sw_alloc_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .nonspec_request   (nonspec_req),
        .spec_request      (spec_req),
        .dest_port         (dest_port),
        .sw_grant          (sw_grant),
        .granted_dest_port (gnt_dest),
        .any_grant         (any_grant),
        .spec_winner       (spec_winner),
        .spec_dest         (spec_dest)
    );

    vc_alloc vc_alloc_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .spec_winner   (spec_winner),
        .spec_dest     (spec_dest),
        .candidate_ovc (cand_ovc),
        .ovc_grant     (ovc_grant),
        .granted_ovc   (granted_ovc),
        .ovc_allocated (ovc_allocated)
    );

    always_comb begin
        for (int i = 0; i < `NOC_P; i++) begin
            port_grant[i].sw_grant          = sw_grant[i];
            port_grant[i].ovc_grant         = ovc_grant[i];
            port_grant[i].granted_ovc       = granted_ovc[i];
            port_grant[i].granted_dest_port = gnt_dest[i];
            port_grant[i].any_grant         = any_grant[i];
        end
    end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter realtime HALF_PERIOD = 2ns // 4 ns period
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

/* comb_spec_alloc_asserts.sv */
`include "noc_alloc_macros.svh"

module comb_spec_alloc_asserts
    import noc_alloc_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input in_port_req_t   port_req      [`NOC_P],
    input in_port_grant_t port_grant    [`NOC_P],
    input vc_vec_t        ovc_allocated [`NOC_P]
);

    timeunit 1ns;
    timeprecision 100ps;

    port_vec_t   out_claim [`NOC_P]; // input ports holding each output
    port_vec_t   ns_claim;           // outputs taken by a non-speculative grant
    vc_vec_t     exp_alloc [`NOC_P];
    vc_vec_t     win_cand  [`NOC_P]; // candidates of the VC that got an output VC
    port_sel_t   win_dest  [`NOC_P]; // requested destination of the VC that won the crossbar
    logic        steady    [`NOC_P];
    logic        all_idle;
    int          wait_cnt  [`NOC_P]; // cycles a steady requester went without grant
    int unsigned fail_count = 0;

    always_comb begin
        int idx;
        all_idle = 1'b1;
        ns_claim = '0;
        for (int o = 0; o < `NOC_P; o++) begin
            out_claim[o] = '0;
            exp_alloc[o] = '0;
        end
        for (int j = 0; j < `NOC_P; j++) begin
            if (|port_req[j].ivc_request) begin
                all_idle = 1'b0;
            end
            win_cand[j] = '0;
            win_dest[j] = '0;
            for (int v = 0; v < `NOC_V; v++) begin
                if (port_grant[j].ovc_grant[v]) begin
                    win_cand[j] = win_cand[j] | port_req[j].candidate_ovc[v];
                end
                if (port_grant[j].sw_grant[v]) begin
                    win_dest[j] = win_dest[j] | port_req[j].dest_port[v];
                end
            end
            // every VC non-speculative and headed to the first other port
            steady[j] = (port_req[j].ivc_request & port_req[j].ovc_is_assigned
                         & port_req[j].assigned_ovc_not_full) == '1;
            for (int v = 0; v < `NOC_V; v++) begin
                if (port_req[j].dest_port[v] != port_sel_t'(1)) begin
                    steady[j] = 1'b0;
                end
            end
            for (int o = 0; o < `NOC_P; o++) begin
                idx = (o < j) ? o : o - 1;
                if (o != j && port_grant[j].granted_dest_port[idx]) begin
                    out_claim[o][j] = 1'b1;
                    exp_alloc[o]    = exp_alloc[o] | port_grant[j].granted_ovc;
                    if (|(port_grant[j].sw_grant & port_req[j].ovc_is_assigned)) begin
                        ns_claim[o] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < `NOC_P; j++) begin
                wait_cnt[j] <= 0;
            end
        end else begin
            for (int j = 0; j < `NOC_P; j++) begin
                if (steady[j] && !port_grant[j].any_grant) begin
                    wait_cnt[j] <= wait_cnt[j] + 1;
                end else begin
                    wait_cnt[j] <= 0;
                end
            end
        end
    end

    for (genvar j = 0; j < `NOC_P; j++) begin : g_port
        a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(port_grant[j].sw_grant) && $onehot0(port_grant[j].ovc_grant)
            && $onehot0(port_grant[j].granted_ovc))
        else begin
            fail_count++;
            $error("** Error port %0d sw_grant=0x%h ovc_grant=0x%h granted_ovc=0x%h not one-hot",
                   j, $sampled(port_grant[j].sw_grant), $sampled(port_grant[j].ovc_grant),
                   $sampled(port_grant[j].granted_ovc));
        end

        // the crossbar grant goes where the winning VC asked to go
        a_dest: assert property (@(posedge clk) disable iff (!rst_n)
            port_grant[j].granted_dest_port == win_dest[j]
            && port_grant[j].any_grant == (|port_grant[j].sw_grant))
        else begin
            fail_count++;
            $error("** Error port %0d granted_dest_port=0x%h expected 0x%h any_grant=0x%h",
                   j, $sampled(port_grant[j].granted_dest_port), $sampled(win_dest[j]),
                   $sampled(port_grant[j].any_grant));
        end

        a_sw_req: assert property (@(posedge clk) disable iff (!rst_n)
            (port_grant[j].sw_grant & ~port_req[j].ivc_request) == '0
            && (port_grant[j].sw_grant & port_req[j].ovc_is_assigned
                & ~port_req[j].assigned_ovc_not_full) == '0)
        else begin
            fail_count++;
            $error("** Error port %0d sw_grant=0x%h ivc_request=0x%h not_full=0x%h", j,
                   $sampled(port_grant[j].sw_grant), $sampled(port_req[j].ivc_request),
                   $sampled(port_req[j].assigned_ovc_not_full));
        end

        a_out_claim: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(out_claim[j]))
        else begin
            fail_count++;
            $error("** Error output %0d claimed by input ports 0x%h", j, $sampled(out_claim[j]));
        end

        // a speculative crossbar grant always comes with a new output VC
        a_ovc_spec: assert property (@(posedge clk) disable iff (!rst_n)
            port_grant[j].ovc_grant == (port_grant[j].sw_grant & ~port_req[j].ovc_is_assigned)
            && ((|port_grant[j].ovc_grant) == (|port_grant[j].granted_ovc))
            && (port_grant[j].granted_ovc & ~win_cand[j]) == '0)
        else begin
            fail_count++;
            $error("** Error port %0d ovc_grant=0x%h sw_grant=0x%h granted_ovc=0x%h cand=0x%h",
                   j, $sampled(port_grant[j].ovc_grant), $sampled(port_grant[j].sw_grant),
                   $sampled(port_grant[j].granted_ovc), $sampled(win_cand[j]));
        end

        a_alloc: assert property (@(posedge clk) disable iff (!rst_n)
            ovc_allocated[j] == exp_alloc[j])
        else begin
            fail_count++;
            $error("** Error ovc_allocated[%0d]=0x%h expected 0x%h", j,
                   $sampled(ovc_allocated[j]), $sampled(exp_alloc[j]));
        end

        a_ns_first: assert property (@(posedge clk) disable iff (!rst_n)
            !((|port_grant[j].ovc_grant)
              && (|(port_grant[j].sw_grant & port_req[j].ovc_is_assigned)))
            && !(ns_claim[j] && (|ovc_allocated[j])))
        else begin
            fail_count++;
            $error("** Error port %0d ovc_grant=0x%h sw_grant=0x%h ovc_allocated=0x%h", j,
                   $sampled(port_grant[j].ovc_grant), $sampled(port_grant[j].sw_grant),
                   $sampled(ovc_allocated[j]));
        end

        a_fair: assert property (@(posedge clk) disable iff (!rst_n)
            wait_cnt[j] < `NOC_P_1)
        else begin
            fail_count++;
            $error("input port %0d kept requesting one output and was starved", j);
        end

        // no disable here, the reset cycles count as idle too
        a_idle: assert property (@(posedge clk)
            all_idle |-> (port_grant[j] == '0 && ovc_allocated[j] == '0))
        else begin
            fail_count++;
            $error("** Error idle port %0d grant=0x%h ovc_allocated=0x%h", j,
                   $sampled(port_grant[j]), $sampled(ovc_allocated[j]));
        end
    end

endmodule

bind comb_spec_alloc comb_spec_alloc_asserts asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .port_req      (port_req),
    .port_grant    (port_grant),
    .ovc_allocated (ovc_allocated)
);

/* comb_spec_alloc_tb.sv */
`include "noc_alloc_macros.svh"

module comb_spec_alloc_tb
    import noc_alloc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SEED = 32'h160e9e2b;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 6;
    localparam int SPEC_CYCLES  = 8;
    localparam int MIX_CYCLES   = 12;
    localparam int FAIR_CYCLES  = 24;
    localparam int RAND_CYCLES  = 800;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * IDLE_CYCLES + SPEC_CYCLES + MIX_CYCLES
                                  + FAIR_CYCLES + RAND_CYCLES + 40;

    logic           clk;
    logic           rst_n;
    in_port_req_t   port_req      [`NOC_P];
    in_port_grant_t port_grant    [`NOC_P];
    vc_vec_t        ovc_allocated [`NOC_P];
    int             cycle_cnt = 0;

    tb_clock_gen clk_gen_i (
        .clk (clk)
    );

    comb_spec_alloc dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .port_req      (port_req),
        .port_grant    (port_grant),
        .ovc_allocated (ovc_allocated)
    );

    // a single requesting VC, room in its output VC
    function automatic in_port_req_t one_vc_req(input int vc, input logic assigned,
                                                input vc_vec_t cand, input port_sel_t dest);
        in_port_req_t r;
        r = '0;
        r.ivc_request[vc]           = 1'b1;
        r.ovc_is_assigned[vc]       = assigned;
        r.assigned_ovc_not_full[vc] = 1'b1;
        r.candidate_ovc[vc]         = assigned ? '0 : cand;
        r.dest_port[vc]             = dest;
        return r;
    endfunction

    function automatic in_port_req_t random_port_req(input logic dense);
        in_port_req_t r;
        r.ivc_request           = dense ? '1 : vc_vec_t'($urandom);
        r.ovc_is_assigned       = vc_vec_t'($urandom);
        r.assigned_ovc_not_full = vc_vec_t'($urandom) | vc_vec_t'($urandom); // mostly room
        for (int v = 0; v < `NOC_V; v++) begin
            r.candidate_ovc[v] = vc_vec_t'($urandom);
            r.dest_port[v]     = port_sel_t'(1 << $urandom_range(0, `NOC_P_1 - 1));
        end
        return r;
    endfunction

    task automatic idle_phase(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            for (int i = 0; i < `NOC_P; i++) begin
                port_req[i] <= '0;
            end
        end
    endtask

    // speculative only, ports 0 and 4 fight for output 2
    task automatic spec_phase();
        repeat (SPEC_CYCLES) begin
            @(posedge clk);
            port_req[0] <= one_vc_req(0, 1'b0, 4'b0110, 4'b0010)
                           | one_vc_req(1, 1'b0, 4'b1001, 4'b0010);
            port_req[1] <= '0;
            port_req[2] <= '0;
            port_req[3] <= one_vc_req(2, 1'b0, 4'b0011, 4'b0001);
            port_req[4] <= one_vc_req(3, 1'b0, 4'b1111, 4'b0100);
        end
    endtask

    // non-speculative traffic knocking out speculation
    task automatic mix_phase();
        in_port_req_t blocked;
        blocked = one_vc_req(0, 1'b1, '0, 4'b0001);
        blocked.assigned_ovc_not_full = '0; // output VC full
        for (int c = 0; c < MIX_CYCLES; c++) begin
            @(posedge clk);
            port_req[0] <= (c % 2 == 1) ? one_vc_req(3, 1'b1, '0, 4'b1000) : '0;
            port_req[1] <= one_vc_req(0, 1'b1, '0, 4'b0001)
                           | one_vc_req(2, 1'b0, 4'b0101, 4'b0010);
            port_req[2] <= one_vc_req(1, 1'b0, 4'b1100, 4'b0001);
            port_req[3] <= one_vc_req(1, 1'b0, 4'b1010, 4'b1000);
            port_req[4] <= blocked;
        end
    endtask

    // ports 1 and 2 both want output 0 on every VC
    task automatic fair_phase();
        in_port_req_t fair;
        fair = '0;
        fair.ivc_request           = '1;
        fair.ovc_is_assigned       = '1;
        fair.assigned_ovc_not_full = '1;
        for (int v = 0; v < `NOC_V; v++) begin
            fair.dest_port[v] = 4'b0001;
        end
        repeat (FAIR_CYCLES) begin
            @(posedge clk);
            for (int i = 0; i < `NOC_P; i++) begin
                port_req[i] <= (i == 1 || i == 2) ? fair : '0;
            end
        end
    endtask

    task automatic random_phase(input int cycles, input logic dense);
        repeat (cycles) begin
            @(posedge clk);
            for (int i = 0; i < `NOC_P; i++) begin
                port_req[i] <= random_port_req(dense);
            end
        end
    endtask

    task automatic finish_run(input logic timed_out);
        int unsigned fails;
        fails = dut_i.asserts_i.fail_count;
        $display("assertion failures: %0d, timeout: %s", fails, timed_out ? "yes" : "no");
        if (!timed_out && fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        for (int i = 0; i < `NOC_P; i++) begin
            port_req[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_phase(IDLE_CYCLES);
        spec_phase();
        mix_phase();
        fair_phase();
        random_phase(RAND_CYCLES / 2, 1'b0);
        random_phase(RAND_CYCLES / 2, 1'b1); // every VC busy
        idle_phase(IDLE_CYCLES);
        @(posedge clk); // last stimulus gets sampled
        finish_run(1'b0);
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            finish_run(1'b1);
        end
    end

endmodule

/* flist.f */
+incdir+.
noc_alloc_pkg.sv
rr_arbiter.sv
sw_alloc_stage.sv
spec_sw_alloc.sv
vc_alloc.sv
comb_spec_alloc.sv
tb_clock_gen.sv
comb_spec_alloc_asserts.sv
comb_spec_alloc_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = comb_spec_alloc_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check the log for the pass message"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
